// File: hdl/game_pkg.sv
package game_pkg;

	//----------------------------------------------------------------------
	// Screen geometry and colour
	//----------------------------------------------------------------------

	typedef logic [7:0] screen_x_t;		// Column 0..159
	typedef logic [6:0] screen_y_t;		// Row 0..119
	typedef logic [8:0] colour_t;		// 3 bits per channel, R in the top bits

	//----------------------------------------------------------------------
	// Level memory
	//----------------------------------------------------------------------

	typedef logic [14:0] level_addr_t;	// Word address into the tile map
	typedef logic [3:0] tile_code_t;	// Tile code returned by the level memory
	typedef logic [15:0] tile_pos_t;	// Level x offset in whole tiles

	// Score display
	typedef logic [3:0] bcd_digit_t;
	typedef logic [6:0] seg7_t;		// Active low, bit 0 is segment a

	// Frame loop phases in execution order
	typedef enum logic [2:0]
	{
		PHASE_BACKGROUND = 3'd0,
		PHASE_CHARACTER = 3'd1,
		PHASE_COLLISIONS = 3'd2,
		PHASE_MOVEMENT = 3'd3,
		PHASE_WAIT = 3'd4
	} game_phase_t;

	//----------------------------------------------------------------------
	// Default timing for a 50 MHz clock
	//----------------------------------------------------------------------

	localparam logic [19:0] DEFAULT_FRAME_CYCLES = 20'd833333;	// 60 frames/s
	localparam logic [25:0] DEFAULT_SCORE_TICK_CYCLES = 26'd50000000;	// One second

endpackage

// File: hdl/pixel_if.sv
`timescale 1ns/1ps

// One pixel write stream toward the frame buffer
interface pixel_if
	import game_pkg::*;
	();

	screen_x_t x;		// Pixel column
	screen_y_t y;		// Pixel row
	colour_t colour;	// Pixel colour
	logic plot;		// Write strobe, one pixel per cycle

	// Drawer side
	modport source
	(
		output x, y, colour, plot
	);

	// Consumer side
	modport sink
	(
		input x, y, colour, plot
	);

endinterface

// File: hdl/frame_sequencer.sv
`timescale 1ns/1ps

module frame_sequencer
	import game_pkg::*;
	#(
		parameter logic [19:0] FRAME_CYCLES = DEFAULT_FRAME_CYCLES
	)
	(
		input logic CLOCK_50,
		input logic resetn,
		input logic draw_background_done,	// Single-cycle strobes
		input logic draw_character_done,
		input logic detect_collisions_done,
		input level_addr_t bg_level_addr,
		input level_addr_t coll_level_addr,
		pixel_if.sink bg_pix,
		pixel_if.sink char_pix,
		pixel_if.source vga_pix,
		output game_phase_t phase,
		output logic draw_background_enable,
		output logic draw_character_enable,
		output logic detect_collisions_enable,
		output logic movement_enable,
		output level_addr_t level_addr
	);

	game_phase_t next_phase;
	logic [19:0] frame_timer;		// Cycles since the background phase ended
	logic frame_elapsed;

	assign frame_elapsed = (frame_timer == FRAME_CYCLES);

	//----------------------------------------------------------------------
	// Phase register
	//----------------------------------------------------------------------

	always_ff @(posedge CLOCK_50 or negedge resetn)
	begin
		if (!resetn)
			phase <= PHASE_BACKGROUND;	// Frame starts drawing at once
		else
			phase <= next_phase;
	end

	// Advance on each done strobe
	always_comb
	begin
		next_phase = phase;
		case (phase)
			PHASE_BACKGROUND:
				if (draw_background_done)
					next_phase = PHASE_CHARACTER;
			PHASE_CHARACTER:
				if (draw_character_done)
					next_phase = PHASE_COLLISIONS;
			PHASE_COLLISIONS:
				if (detect_collisions_done)
					next_phase = PHASE_MOVEMENT;
			PHASE_MOVEMENT:
				next_phase = PHASE_WAIT;	// Single cycle
			PHASE_WAIT:
				if (frame_elapsed)
					next_phase = PHASE_BACKGROUND;
			default:
				next_phase = PHASE_BACKGROUND;	// Recover from unused codes
		endcase
	end

	//----------------------------------------------------------------------
	// Frame timer
	//----------------------------------------------------------------------

	always_ff @(posedge CLOCK_50 or negedge resetn)
	begin
		if (!resetn)
			frame_timer <= '0;
		else if (phase == PHASE_BACKGROUND)
			frame_timer <= '0;		// Held clear while drawing background
		else if (!frame_elapsed)
			frame_timer <= frame_timer + 20'd1;	// Saturate at the frame length
	end

	// Moore enables, one per phase
	assign draw_background_enable = (phase == PHASE_BACKGROUND);
	assign draw_character_enable = (phase == PHASE_CHARACTER);
	assign detect_collisions_enable = (phase == PHASE_COLLISIONS);
	assign movement_enable = (phase == PHASE_MOVEMENT);

	//----------------------------------------------------------------------
	// Shared bus steering
	//----------------------------------------------------------------------

	always_comb
	begin
		vga_pix.x = '0;		// Idle bus outside drawing phases
		vga_pix.y = '0;
		vga_pix.colour = '0;
		vga_pix.plot = 1'b0;
		case (phase)
			PHASE_BACKGROUND:
			begin
				vga_pix.x = bg_pix.x;
				vga_pix.y = bg_pix.y;
				vga_pix.colour = bg_pix.colour;
				vga_pix.plot = bg_pix.plot;
			end
			PHASE_CHARACTER:
			begin
				vga_pix.x = char_pix.x;
				vga_pix.y = char_pix.y;
				vga_pix.colour = char_pix.colour;
				vga_pix.plot = char_pix.plot;
			end
			default:
			begin
				vga_pix.plot = 1'b0;
			end
		endcase
	end

	// Level memory owner
	always_comb
	begin
		case (phase)
			PHASE_BACKGROUND: level_addr = bg_level_addr;	// Tile fetch
			PHASE_COLLISIONS: level_addr = coll_level_addr;	// Neighbour lookup
			default: level_addr = '0;
		endcase
	end

endmodule

// File: hdl/scroll_control.sv
`timescale 1ns/1ps

module scroll_control
	import game_pkg::*;
	(
		input logic CLOCK_50,
		input logic resetn,
		input logic movement_enable,	// High for the one movement cycle
		input logic key_left,		// Active low
		input logic key_right,		// Active low
		input logic left_blocked,
		input logic right_blocked,
		output tile_pos_t tile_pos
	);

	logic move_right;
	logic move_left;

	//----------------------------------------------------------------------
	// Move requests
	//----------------------------------------------------------------------

	// Right wins when both keys are down
	assign move_right = !key_right && !right_blocked;

	// Left only considered without a right move
	assign move_left = !key_left && !left_blocked && !move_right;

	//----------------------------------------------------------------------
	// Offset register
	//----------------------------------------------------------------------

	always_ff @(posedge CLOCK_50 or negedge resetn)
	begin
		if (!resetn)
		begin
			tile_pos <= '0;		// Level start
		end
		else if (movement_enable)
		begin
			if (move_right)
				tile_pos <= tile_pos + 16'd1;	// Wraps at 2^16
			else if (move_left)
				tile_pos <= tile_pos - 16'd1;	// 0 goes to 65535
		end
	end

endmodule

// File: hdl/score_counter.sv
`timescale 1ns/1ps

module score_counter
	import game_pkg::*;
	#(
		parameter logic [25:0] SCORE_TICK_CYCLES = DEFAULT_SCORE_TICK_CYCLES
	)
	(
		input logic CLOCK_50,
		input logic resetn,
		output seg7_t hex0,		// Units
		output seg7_t hex1,		// Tens
		output seg7_t hex2		// Hundreds
	);

	logic [25:0] prescale;
	logic tick;
	bcd_digit_t digit [3];
	logic [3:0] carry;		// carry[i] advances digit i

	// Digit to active-low segments, bit 0 is segment a
	function automatic seg7_t seg_decode(input bcd_digit_t d);
		case (d)
			4'd0: seg_decode = 7'b1000000;	// All but g
			4'd1: seg_decode = 7'b1111001;
			4'd2: seg_decode = 7'b0100100;
			4'd3: seg_decode = 7'b0110000;
			4'd4: seg_decode = 7'b0011001;
			4'd5: seg_decode = 7'b0010010;
			4'd6: seg_decode = 7'b0000010;
			4'd7: seg_decode = 7'b1111000;
			4'd8: seg_decode = 7'b0000000;
			4'd9: seg_decode = 7'b0010000;
			default: seg_decode = 7'b1111111;	// Blank
		endcase
	endfunction

	//----------------------------------------------------------------------
	// Prescaler
	//----------------------------------------------------------------------

	assign tick = (prescale == SCORE_TICK_CYCLES - 26'd1);

	always_ff @(posedge CLOCK_50 or negedge resetn)
	begin
		if (!resetn)
			prescale <= '0;
		else if (tick)
			prescale <= '0;
		else
			prescale <= prescale + 26'd1;
	end

	//----------------------------------------------------------------------
	// Decimal counter chain
	//----------------------------------------------------------------------

	assign carry[0] = tick;
	assign carry[1] = carry[0] && (digit[0] == 4'd9);	// Units roll over
	assign carry[2] = carry[1] && (digit[1] == 4'd9);
	assign carry[3] = carry[2] && (digit[2] == 4'd9);	// 999 to 000

	always_ff @(posedge CLOCK_50 or negedge resetn)
	begin
		if (!resetn)
		begin
			for (int i = 0; i < 3; i++)
				digit[i] <= '0;
		end
		else
		begin
			for (int i = 0; i < 3; i++)
				if (carry[i])
					digit[i] <= carry[i+1] ? 4'd0 : digit[i] + 4'd1;
		end
	end

	// Display drivers
	assign hex0 = seg_decode(digit[0]);
	assign hex1 = seg_decode(digit[1]);
	assign hex2 = seg_decode(digit[2]);

endmodule

// File: hdl/game_core.sv
`timescale 1ns/1ps

module game_core
	import game_pkg::*;
	#(
		parameter logic [19:0] FRAME_CYCLES = DEFAULT_FRAME_CYCLES,
		parameter logic [25:0] SCORE_TICK_CYCLES = DEFAULT_SCORE_TICK_CYCLES
	)
	(
		input logic CLOCK_50,
		input logic resetn,
		input logic key_left,			// Push keys, active low
		input logic key_right,
		input logic draw_background_done,
		input logic draw_character_done,
		input logic detect_collisions_done,
		input logic left_blocked,		// From the collision detector
		input logic right_blocked,
		input screen_x_t bg_x,			// Background drawer stream
		input screen_y_t bg_y,
		input colour_t bg_colour,
		input logic bg_plot,
		input level_addr_t bg_level_addr,
		input screen_x_t char_x,		// Character drawer stream
		input screen_y_t char_y,
		input colour_t char_colour,
		input logic char_plot,
		input level_addr_t coll_level_addr,
		output logic draw_background_enable,
		output logic draw_character_enable,
		output logic detect_collisions_enable,
		output logic movement_enable,
		output game_phase_t phase,
		output screen_x_t vga_x,		// Toward the VGA adapter
		output screen_y_t vga_y,
		output colour_t vga_colour,
		output logic vga_plot,
		output level_addr_t level_addr,
		output tile_pos_t tile_pos,
		output seg7_t hex0,
		output seg7_t hex1,
		output seg7_t hex2
	);

	//----------------------------------------------------------------------
	// Pixel streams
	//----------------------------------------------------------------------

	pixel_if bg_pix ();
	pixel_if char_pix ();
	pixel_if vga_pix ();

	assign bg_pix.x = bg_x;
	assign bg_pix.y = bg_y;
	assign bg_pix.colour = bg_colour;
	assign bg_pix.plot = bg_plot;

	assign char_pix.x = char_x;
	assign char_pix.y = char_y;
	assign char_pix.colour = char_colour;
	assign char_pix.plot = char_plot;

	assign vga_x = vga_pix.x;
	assign vga_y = vga_pix.y;
	assign vga_colour = vga_pix.colour;
	assign vga_plot = vga_pix.plot;

	//----------------------------------------------------------------------
	// Frame loop
	//----------------------------------------------------------------------

	frame_sequencer #(
		.FRAME_CYCLES(FRAME_CYCLES)
	) u_sequencer (
		.CLOCK_50(CLOCK_50),
		.resetn(resetn),
		.draw_background_done(draw_background_done),
		.draw_character_done(draw_character_done),
		.detect_collisions_done(detect_collisions_done),
		.bg_level_addr(bg_level_addr),
		.coll_level_addr(coll_level_addr),
		.bg_pix(bg_pix.sink),
		.char_pix(char_pix.sink),
		.vga_pix(vga_pix.source),
		.phase(phase),
		.draw_background_enable(draw_background_enable),
		.draw_character_enable(draw_character_enable),
		.detect_collisions_enable(detect_collisions_enable),
		.movement_enable(movement_enable),
		.level_addr(level_addr)
	);

	// Level offset, stepped once per frame
	scroll_control u_scroll (
		.CLOCK_50(CLOCK_50),
		.resetn(resetn),
		.movement_enable(movement_enable),
		.key_left(key_left),
		.key_right(key_right),
		.left_blocked(left_blocked),
		.right_blocked(right_blocked),
		.tile_pos(tile_pos)
	);

	// Elapsed seconds on the displays
	score_counter #(
		.SCORE_TICK_CYCLES(SCORE_TICK_CYCLES)
	) u_score (
		.CLOCK_50(CLOCK_50),
		.resetn(resetn),
		.hex0(hex0),
		.hex1(hex1),
		.hex2(hex2)
	);

endmodule

// File: tests/game_core_properties.sv
`timescale 1ns/1ps

// Phase output rules of the frame loop
module game_core_properties
	import game_pkg::*;
	(
		input logic CLOCK_50,
		input logic resetn,
		input logic draw_background_enable,
		input logic draw_character_enable,
		input logic detect_collisions_enable,
		input logic movement_enable,
		input game_phase_t phase,
		input logic vga_plot
	);

	logic [3:0] enables;
	logic drawing;			// A drawer owns the VGA bus
	int failures = 0;		// Failed assertion count

	assign enables = {draw_background_enable, draw_character_enable,
		detect_collisions_enable, movement_enable};
	assign drawing = (phase == PHASE_BACKGROUND) || (phase == PHASE_CHARACTER);

	// One owner per phase at most
	one_enable: assert property (@(posedge CLOCK_50) disable iff (!resetn)
		$onehot0(enables))
	else
	begin
		$error("More than one phase enable high: %b", enables);
		failures++;
	end

	// Movement is a single-cycle phase
	single_move: assert property (@(posedge CLOCK_50) disable iff (!resetn)
		movement_enable |=> !movement_enable)
	else
	begin
		$error("movement_enable high on two consecutive cycles");
		failures++;
	end

	idle_plot: assert property (@(posedge CLOCK_50) disable iff (!resetn)
		!drawing |-> !vga_plot)
	else
	begin
		$error("vga_plot high in phase %s", phase.name());
		failures++;
	end

endmodule

bind game_core game_core_properties u_props
(
	.CLOCK_50(CLOCK_50),
	.resetn(resetn),
	.draw_background_enable(draw_background_enable),
	.draw_character_enable(draw_character_enable),
	.detect_collisions_enable(detect_collisions_enable),
	.movement_enable(movement_enable),
	.phase(phase),
	.vga_plot(vga_plot)
);

// File: tests/game_core_tb.sv
`timescale 1ns/1ps

module game_core_tb
	import game_pkg::*;
	();

	localparam logic [19:0] FRAME_CYCLES = 20'd40;
	localparam logic [25:0] SCORE_TICK_CYCLES = 26'd300;
	localparam int NUM_FRAMES = 24;
	localparam int RESET_CYCLES = 5;
	localparam int PHASE_BOUND = 8;		// Worst drawer or detector latency, rounded up
	localparam int CYCLE_LIMIT = NUM_FRAMES * (int'(FRAME_CYCLES) + 3 * PHASE_BOUND) * 2
		+ RESET_CYCLES;
	localparam int unsigned RANDOM_SEED = 32'h1fd9_7765;

	// One table row per frame, keys active low
	typedef struct packed
	{
		logic key_left;
		logic key_right;
		logic left_blocked;
		logic right_blocked;
		logic signed [1:0] delta;	// Expected tile_pos change
	} scroll_row_t;

	logic CLOCK_50, resetn;
	logic key_left, key_right, left_blocked, right_blocked;
	logic draw_background_done, draw_character_done, detect_collisions_done;
	screen_x_t bg_x, char_x, vga_x;
	screen_y_t bg_y, char_y, vga_y;
	colour_t bg_colour, char_colour, vga_colour;
	logic bg_plot, char_plot, vga_plot;
	level_addr_t bg_level_addr, coll_level_addr, level_addr;
	logic draw_background_enable, draw_character_enable;
	logic detect_collisions_enable, movement_enable;
	game_phase_t phase;
	tile_pos_t tile_pos;
	seg7_t hex0, hex1, hex2;
	logic [3:0] enables;

	int errors = 0;
	int checks = 0;
	int cycle_count = 0;		// All clock edges, reset included
	int elapsed = 0;		// Edges seen with reset released
	int leave_bg_cycle = 0;
	tile_pos_t expected_pos = '0;

	// Active-low digit patterns, bit 0 is segment a
	seg7_t digit_segments [10] = '{7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
		7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000, 7'b0000000, 7'b0010000};

	scroll_row_t scroll_table [NUM_FRAMES] = '{
		'{1'b0, 1'b1, 1'b0, 1'b0, -2'sd1},	// Left from 0, wraps to 65535
		'{1'b1, 1'b0, 1'b0, 1'b0, 2'sd1},	// Back to 0
		'{1'b1, 1'b0, 1'b0, 1'b0, 2'sd1},
		'{1'b0, 1'b0, 1'b0, 1'b0, 2'sd1},	// Both keys, right wins
		'{1'b1, 1'b1, 1'b0, 1'b0, 2'sd0},	// No key
		'{1'b1, 1'b0, 1'b0, 1'b1, 2'sd0},	// Right blocked
		'{1'b0, 1'b1, 1'b1, 1'b0, 2'sd0},	// Left blocked
		'{1'b0, 1'b0, 1'b0, 1'b1, -2'sd1},	// Both keys, right blocked
		'{1'b0, 1'b0, 1'b1, 1'b0, 2'sd1},	// Both keys, left blocked
		'{1'b0, 1'b0, 1'b1, 1'b1, 2'sd0},	// Everything blocked
		'{1'b0, 1'b1, 1'b0, 1'b0, -2'sd1},
		'{1'b0, 1'b1, 1'b0, 1'b0, -2'sd1},
		'{1'b0, 1'b1, 1'b0, 1'b0, -2'sd1},	// Below zero again
		'{1'b0, 1'b1, 1'b0, 1'b0, -2'sd1},
		'{1'b1, 1'b1, 1'b1, 1'b1, 2'sd0},
		'{1'b1, 1'b0, 1'b0, 1'b0, 2'sd1},
		'{1'b1, 1'b0, 1'b1, 1'b0, 2'sd1},	// Other side blocked only
		'{1'b0, 1'b1, 1'b0, 1'b1, -2'sd1},
		'{1'b1, 1'b1, 1'b0, 1'b0, 2'sd0},
		'{1'b1, 1'b0, 1'b0, 1'b0, 2'sd1},
		'{1'b1, 1'b0, 1'b0, 1'b0, 2'sd1},
		'{1'b0, 1'b0, 1'b0, 1'b0, 2'sd1},
		'{1'b0, 1'b1, 1'b0, 1'b0, -2'sd1},
		'{1'b1, 1'b1, 1'b0, 1'b0, 2'sd0}
	};

	assign enables = {draw_background_enable, draw_character_enable,
		detect_collisions_enable, movement_enable};

	game_core #(
		.FRAME_CYCLES(FRAME_CYCLES),
		.SCORE_TICK_CYCLES(SCORE_TICK_CYCLES)
	) dut (.*);

	//----------------------------------------------------------------------
	// Clock, cycle counters and timeout
	//----------------------------------------------------------------------

	initial CLOCK_50 = 1'b0;
	always #20 CLOCK_50 = ~CLOCK_50;

	always @(posedge CLOCK_50)
	begin
		cycle_count <= cycle_count + 1;
		if (resetn)
			elapsed <= elapsed + 1;		// Same edges as the prescaler
	end

	always @(negedge CLOCK_50)
	begin
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("Timeout: frame loop still running after %0d cycles", CYCLE_LIMIT);
			$display("Checks: %0d, errors: %0d", checks, errors);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	//----------------------------------------------------------------------
	// Compare tasks
	//----------------------------------------------------------------------

	task automatic check_phase(input game_phase_t actual, input logic [3:0] en,
		input game_phase_t expected);
		logic [3:0] exp_en;
		exp_en = 4'b0000;
		case (expected)
			PHASE_BACKGROUND: exp_en = 4'b1000;
			PHASE_CHARACTER: exp_en = 4'b0100;
			PHASE_COLLISIONS: exp_en = 4'b0010;
			PHASE_MOVEMENT: exp_en = 4'b0001;
			default: exp_en = 4'b0000;	// Wait phase, nothing enabled
		endcase
		checks++;
		if (actual !== expected || en !== exp_en)
		begin
			errors++;
			$display("[ERROR] %0t: phase %s enables %b, expected %s enables %b",
				$time, actual.name(), en, expected.name(), exp_en);
		end
	endtask

	task automatic check_tile_pos(input tile_pos_t actual, input tile_pos_t expected);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("[ERROR] %0t: tile_pos %0d, expected %0d", $time, actual, expected);
		end
	endtask

	task automatic check_pixel(input screen_x_t x, input screen_y_t y, input colour_t colour,
		input logic plot, input screen_x_t exp_x, input screen_y_t exp_y,
		input colour_t exp_colour, input logic exp_plot);
		checks++;
		if (x !== exp_x || y !== exp_y || colour !== exp_colour || plot !== exp_plot)
		begin
			errors++;
			$display("[ERROR] %0t: vga pixel (%0d,%0d) %h plot %b, expected (%0d,%0d) %h plot %b",
				$time, x, y, colour, plot, exp_x, exp_y, exp_colour, exp_plot);
		end
	endtask

	task automatic check_level_addr(input level_addr_t actual, input level_addr_t expected);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("[ERROR] %0t: level_addr %h, expected %h", $time, actual, expected);
		end
	endtask

	task automatic check_seg(input seg7_t actual, input seg7_t expected, input string which);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("[ERROR] %0t: %s shows %b, expected %b", $time, which, actual, expected);
		end
	endtask

	// Whole seconds since reset, three digits
	task automatic verify_score();
		int score;
		bcd_digit_t units, tens, hundreds;
		score = (elapsed / int'(SCORE_TICK_CYCLES)) % 1000;
		units = bcd_digit_t'(score % 10);
		tens = bcd_digit_t'((score / 10) % 10);
		hundreds = bcd_digit_t'(score / 100);
		check_seg(hex0, digit_segments[units], "hex0");
		check_seg(hex1, digit_segments[tens], "hex1");
		check_seg(hex2, digit_segments[hundreds], "hex2");
	endtask

	//----------------------------------------------------------------------
	// Drawer and detector models
	//----------------------------------------------------------------------

	// Random pixel every cycle, done on the last one; bus left stale afterwards
	task automatic drive_drawer(input game_phase_t ph);
		int latency;
		logic last;
		screen_x_t x;
		screen_y_t y;
		colour_t c;
		level_addr_t a;
		latency = $urandom_range(6, 1);
		for (int i = 0; i < latency; i++)
		begin
			@(posedge CLOCK_50);
			last = (i == latency - 1);
			x = screen_x_t'($urandom_range(159, 0));
			y = screen_y_t'($urandom_range(119, 0));
			c = colour_t'($urandom);
			a = level_addr_t'($urandom);
			if (ph == PHASE_BACKGROUND)
			begin
				bg_x <= x;
				bg_y <= y;
				bg_colour <= c;
				bg_plot <= 1'b1;
				bg_level_addr <= a;
			end
			else
			begin
				char_x <= x;
				char_y <= y;
				char_colour <= c;
				char_plot <= 1'b1;
				bg_level_addr <= a;	// Must not reach the level memory here
			end
			draw_background_done <= (ph == PHASE_BACKGROUND) && last;
			draw_character_done <= (ph == PHASE_CHARACTER) && last;
			@(negedge CLOCK_50);
			if (ph == PHASE_CHARACTER && i == 0)
				leave_bg_cycle = cycle_count;	// First cycle of the frame timer
			check_phase(phase, enables, ph);
			check_pixel(vga_x, vga_y, vga_colour, vga_plot, x, y, c, 1'b1);
			check_level_addr(level_addr, (ph == PHASE_BACKGROUND) ? a : '0);
		end
	endtask

	// Flags valid for the whole detection, keys pressed alongside
	task automatic drive_detector(input scroll_row_t row);
		int latency;
		level_addr_t a;
		latency = $urandom_range(6, 1);
		for (int i = 0; i < latency; i++)
		begin
			@(posedge CLOCK_50);
			a = level_addr_t'($urandom);
			coll_level_addr <= a;
			key_left <= row.key_left;
			key_right <= row.key_right;
			left_blocked <= row.left_blocked;
			right_blocked <= row.right_blocked;
			draw_character_done <= 1'b0;
			detect_collisions_done <= (i == latency - 1);
			@(negedge CLOCK_50);
			check_phase(phase, enables, PHASE_COLLISIONS);
			check_pixel(vga_x, vga_y, vga_colour, vga_plot, '0, '0, '0, 1'b0);
			check_level_addr(level_addr, a);
		end
	endtask

	task automatic play_frame(input scroll_row_t row);
		int d;
		drive_drawer(PHASE_BACKGROUND);
		drive_drawer(PHASE_CHARACTER);
		drive_detector(row);
		@(posedge CLOCK_50);
		detect_collisions_done <= 1'b0;
		@(negedge CLOCK_50);
		check_phase(phase, enables, PHASE_MOVEMENT);	// Single movement cycle
		check_level_addr(level_addr, '0);
		d = int'(row.delta);
		expected_pos = expected_pos + tile_pos_t'(d);
		@(negedge CLOCK_50);
		check_phase(phase, enables, PHASE_WAIT);
		check_tile_pos(tile_pos, expected_pos);
		verify_score();
		do
		begin
			check_pixel(vga_x, vga_y, vga_colour, vga_plot, '0, '0, '0, 1'b0);
			@(negedge CLOCK_50);
		end while (!draw_background_enable);
		check_phase(phase, enables, PHASE_BACKGROUND);
		checks++;
		if (cycle_count - leave_bg_cycle < int'(FRAME_CYCLES))
		begin
			errors++;
			$display("[ERROR] %0t: frame restarted after %0d cycles, minimum %0d",
				$time, cycle_count - leave_bg_cycle, FRAME_CYCLES);
		end
	endtask

	//----------------------------------------------------------------------
	// Main sequence
	//----------------------------------------------------------------------

	initial
	begin
		void'($urandom(RANDOM_SEED));
		resetn = 1'b0;
		key_left = 1'b1;		// Keys released
		key_right = 1'b1;
		left_blocked = 1'b0;
		right_blocked = 1'b0;
		draw_background_done = 1'b0;
		draw_character_done = 1'b0;
		detect_collisions_done = 1'b0;
		bg_x = '0;
		bg_y = '0;
		bg_colour = '0;
		bg_plot = 1'b0;
		bg_level_addr = '0;
		char_x = '0;
		char_y = '0;
		char_colour = '0;
		char_plot = 1'b0;
		coll_level_addr = '0;
		repeat (RESET_CYCLES) @(posedge CLOCK_50);
		resetn <= 1'b1;
		@(negedge CLOCK_50);
		check_phase(phase, enables, PHASE_BACKGROUND);	// State right after reset
		check_tile_pos(tile_pos, '0);
		check_pixel(vga_x, vga_y, vga_colour, vga_plot, '0, '0, '0, 1'b0);
		check_seg(hex0, digit_segments[0], "hex0");
		check_seg(hex1, digit_segments[0], "hex1");
		check_seg(hex2, digit_segments[0], "hex2");
		for (int f = 0; f < NUM_FRAMES; f++)
			play_frame(scroll_table[f]);
		errors += dut.u_props.failures;
		$display("Checks: %0d, errors: %0d, assertion failures: %0d",
			checks, errors, dut.u_props.failures);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: game_core.f
hdl/game_pkg.sv
hdl/pixel_if.sv
hdl/frame_sequencer.sv
hdl/scroll_control.sv
hdl/score_counter.sv
hdl/game_core.sv
tests/game_core_properties.sv
tests/game_core_tb.sv

// File: Makefile
# Verilator build and run of the frame loop testbench

VERILATOR ?= verilator
TOP ?= game_core_tb
FILELIST ?= game_core.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --assert -j 0
SIM_ARGS ?= +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
